// ==== bench/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb;
	import ex_pkg::*;

	localparam int alu_vectors     = 300;
	localparam int jr_vectors      = 40;
	localparam int invalid_vectors = 150;
	localparam int mixed_vectors   = 300;
	// reset, alu, 72 source combos, 96 branch cases, redirect tests
	localparam int stim_cycles     = 20 + alu_vectors + 72 + 96 + jr_vectors
		+ invalid_vectors + mixed_vectors;
	localparam int timeout_cycles  = 3 * stim_cycles;

	logic    clk;
	logic    rst_n;
	logic    checking;
	ex_in_t  in_drv;
	ex_out_t out;
	ex_out_t exp_q;   // model output, lines up with out
	int      errors = 0;
	int      cycles = 0;
	int      pass_count = 0;
	int      fail_count = 0;

	src_b_e          b_sources [6] = '{src_b_rs2, src_b_mem, src_b_ex,
		src_b_zero, src_b_imm, src_b_one};
	logic [xlen-1:0] br_a [8] = '{32'd5, 32'hffffffff, 32'd1, 32'h80000000,
		32'h7fffffff, 32'h80000000, 32'h7fffffff, 32'd0};
	logic [xlen-1:0] br_b [8] = '{32'd5, 32'd1, 32'hffffffff, 32'h7fffffff,
		32'h80000000, 32'h80000000, 32'h7fffffff, 32'hffffffff};

	ex_stage uut (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (in_drv),
		.out   (out)
	);

	always #2 clk = ~clk;

	// ######################################################################
	// reference model
	// ######################################################################
	function automatic ex_out_t expected_out(ex_in_t v);
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] st;
		logic [xlen-1:0] r;
		logic            eq;
		logic            lt;
		logic            tk;
		logic            br;
		logic            wrong;
		ex_out_t         o;
		o = '0;
		if (v.sel_a == src_a_pc) a = v.pc;
		else if (v.sel_a == src_a_ex) a = v.ex_fwd;
		else if (v.sel_a == src_a_mem) a = v.mem_fwd;
		else a = v.rs1;
		case (v.sel_b)
			src_b_rs2:  b = v.rs2;
			src_b_mem:  b = v.mem_fwd;
			src_b_ex:   b = v.ex_fwd;
			src_b_zero: b = 32'd0;
			src_b_one:  b = 32'd1;
			default:    b = v.imm; // imm and unused codes
		endcase
		case (v.sel_st)
			src_st_ex:  st = v.ex_fwd;
			src_st_mem: st = v.mem_fwd;
			src_st_rs2: st = v.rs2;
			default:    st = 32'd0;
		endcase
		eq = (a == b);
		lt = ($signed(a) < $signed(b));
		br = (v.op >= op_beq) && (v.op <= op_bge);
		case (v.op)
			op_beq:  tk = eq;
			op_bne:  tk = !eq;
			op_blt:  tk = lt;
			op_ble:  tk = lt || eq;
			op_bgt:  tk = !lt && !eq;
			op_bge:  tk = !lt;
			default: tk = 1'b0;
		endcase
		case (v.op)
			op_add:  r = a + b;
			op_sub:  r = a - b;
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_xor:  r = a ^ b;
			op_sll:  r = a << b[4:0];
			op_srl:  r = a >> b[4:0];
			op_sra:  r = $signed(a) >>> b[4:0];
			op_slt:  r = {{(xlen-1){1'b0}}, lt};
			op_jr:   r = a;
			default: r = br ? a - b : 32'd0;
		endcase
		wrong = (br && (tk != v.predicted)) || (v.op == op_jr);
		if (v.valid) begin
			o.valid            = 1'b1;
			o.alu_result       = r;
			o.store_data       = st;
			o.rd               = v.rd;
			o.rd_nonzero       = (v.rd != 5'd0);
			o.reg_write        = v.reg_write;
			o.mem_read         = v.mem_read;
			o.mem_write        = v.mem_write;
			o.wrong_prediction = wrong;
			o.redirect_pc      = wrong ? ((v.op == op_jr) ? a : v.alt_pc) : 32'd0;
		end
		return o;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			exp_q <= '0;
		else
			exp_q <= expected_out(in_drv);
	end

	// ######################################################################
	// checks
	// ######################################################################
	a_reset_state: assert property (@(posedge clk) disable iff (!checking)
		!rst_n |-> (!out.valid && !out.wrong_prediction && !out.reg_write
			&& !out.mem_read && !out.mem_write))
		else begin
			$display("MISMATCH %0t: outputs not cleared during reset", $time);
			errors++;
		end

	a_valid: assert property (@(posedge clk) disable iff (!checking)
		out.valid == exp_q.valid)
		else begin
			$display("MISMATCH %0t: valid got %b expected %b", $time,
				$sampled(out.valid), $sampled(exp_q.valid));
			errors++;
		end

	a_result: assert property (@(posedge clk) disable iff (!checking)
		out.alu_result == exp_q.alu_result)
		else begin
			$display("MISMATCH %0t: alu_result got %h expected %h", $time,
				$sampled(out.alu_result), $sampled(exp_q.alu_result));
			errors++;
		end

	a_store: assert property (@(posedge clk) disable iff (!checking)
		out.store_data == exp_q.store_data)
		else begin
			$display("MISMATCH %0t: store_data got %h expected %h", $time,
				$sampled(out.store_data), $sampled(exp_q.store_data));
			errors++;
		end

	a_dest: assert property (@(posedge clk) disable iff (!checking)
		out.rd == exp_q.rd && out.rd_nonzero == exp_q.rd_nonzero
		&& out.reg_write == exp_q.reg_write && out.mem_read == exp_q.mem_read
		&& out.mem_write == exp_q.mem_write)
		else begin
			$display("MISMATCH %0t: rd or control flags differ from model", $time);
			errors++;
		end

	a_predict: assert property (@(posedge clk) disable iff (!checking)
		out.wrong_prediction == exp_q.wrong_prediction
		&& out.redirect_pc == exp_q.redirect_pc)
		else begin
			$display("MISMATCH %0t: wrong_prediction %b redirect %h expected %b %h",
				$time, $sampled(out.wrong_prediction), $sampled(out.redirect_pc),
				$sampled(exp_q.wrong_prediction), $sampled(exp_q.redirect_pc));
			errors++;
		end

	a_bubble: assert property (@(posedge clk) disable iff (!checking)
		!$past(in_drv.valid) |-> (!out.valid && !out.wrong_prediction))
		else begin
			$display("MISMATCH %0t: bubble produced a valid output or a redirect",
				$time);
			errors++;
		end

	// ######################################################################
	// timeout
	// ######################################################################
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("run timed out after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ######################################################################
	// stimulus helpers
	// ######################################################################
	function automatic ex_in_t random_instr(ex_op_e op);
		ex_in_t v;
		v           = '0;
		v.valid     = 1'b1;
		v.op        = op;
		v.pc        = $urandom;
		v.rs1       = $urandom;
		v.rs2       = $urandom;
		v.imm       = $urandom;
		v.ex_fwd    = $urandom;
		v.mem_fwd   = $urandom;
		v.sel_a     = src_a_rs1;
		v.sel_b     = src_b_rs2;
		v.sel_st    = src_st_rs2;
		v.rd        = 5'($urandom);
		v.reg_write = 1'($urandom);
		v.mem_read  = 1'($urandom);
		v.mem_write = 1'($urandom);
		v.predicted = 1'($urandom);
		v.alt_pc    = $urandom;
		return v;
	endfunction

	task automatic drive(input ex_in_t v);
		@(negedge clk);
		in_drv = v;
	endtask

	// flush the last instruction past its check, then report
	task automatic end_test(input string name, input int errors_before);
		int n;
		drive('0);
		@(negedge clk);
		n = errors - errors_before;
		if (n == 0) begin
			pass_count++;
			$display("%-18s pass", name);
		end else begin
			fail_count++;
			$display("%-18s fail, %0d check errors", name, n);
		end
	endtask

	// ######################################################################
	// tests
	// ######################################################################
	task automatic check_reset_latency();
		int e0;
		e0 = errors;
		@(negedge clk);
		checking = 1'b1;
		@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		drive('0);
		for (int i = 0; i < 4; i++)
			drive(random_instr(op_add)); // back to back
		drive('0);
		drive(random_instr(op_sub));
		end_test("reset_latency", e0);
	endtask

	task automatic run_alu_ops();
		int     e0;
		ex_in_t v;
		e0 = errors;
		for (int i = 0; i < alu_vectors; i++) begin
			v = random_instr(ex_op_e'(1 + $urandom_range(8)));
			if (i % 4 == 0)
				v.rs2[4:0] = 5'h1f;
			drive(v);
		end
		end_test("alu_ops", e0);
	endtask

	task automatic run_forwarding();
		int     e0;
		int     n;
		ex_in_t v;
		e0 = errors;
		n  = 0;
		for (int sa = 0; sa < 4; sa++)
			for (int sb = 0; sb < 6; sb++)
				for (int ss = 0; ss < 3; ss++) begin
					v         = random_instr(op_add);
					// distinct top bytes keep every source apart
					v.rs1     = 32'h1100_0000 | ($urandom & 32'h00ff_ffff);
					v.rs2     = 32'h2200_0000 | ($urandom & 32'h00ff_ffff);
					v.ex_fwd  = 32'h3300_0000 | ($urandom & 32'h00ff_ffff);
					v.mem_fwd = 32'h4400_0000 | ($urandom & 32'h00ff_ffff);
					v.imm     = 32'h5500_0000 | ($urandom & 32'h00ff_ffff);
					v.pc      = 32'h6600_0000 | ($urandom & 32'h00ff_fffc);
					v.sel_a   = src_a_e'(sa);
					v.sel_b   = b_sources[sb];
					v.sel_st  = src_st_e'(ss);
					if (n % 5 == 0)
						v.rd = 5'd0;
					n++;
					drive(v);
				end
		end_test("forwarding", e0);
	endtask

	task automatic run_branches();
		int     e0;
		ex_in_t v;
		e0 = errors;
		for (int op = int'(op_beq); op <= int'(op_bge); op++)
			for (int p = 0; p < 8; p++)
				for (int pr = 0; pr < 2; pr++) begin
					v           = random_instr(ex_op_e'(op));
					v.rs1       = br_a[p];
					v.rs2       = br_b[p];
					v.predicted = pr[0];
					drive(v);
				end
		end_test("branches", e0);
	endtask

	task automatic run_redirects();
		int     e0;
		ex_in_t v;
		e0 = errors;
		for (int i = 0; i < jr_vectors; i++) begin
			v       = random_instr(op_jr);
			v.sel_a = src_a_e'(i % 4);
			drive(v);
		end
		for (int i = 0; i < invalid_vectors; i++) begin
			v       = random_instr(ex_op_e'($urandom_range(16)));
			v.valid = 1'b0;
			v.sel_a = src_a_e'($urandom_range(3));
			drive(v);
		end
		// random mix of everything, valid or not
		for (int i = 0; i < mixed_vectors; i++) begin
			v        = random_instr(ex_op_e'($urandom_range(16)));
			v.valid  = ($urandom_range(7) != 0);
			v.sel_a  = src_a_e'($urandom_range(3));
			v.sel_b  = b_sources[$urandom_range(5)];
			v.sel_st = src_st_e'($urandom_range(2));
			drive(v);
		end
		end_test("redirects", e0);
	endtask

	initial begin
		void'($urandom(33));
		clk      = 1'b0;
		rst_n    = 1'b0;
		checking = 1'b0;
		in_drv   = '0;
		check_reset_latency();
		run_alu_ops();
		run_forwarding();
		run_branches();
		run_redirects();
		$display("tests passed %0d, failed %0d, check errors %0d",
			pass_count, fail_count, errors);
		if (fail_count == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== ex_stage.f ====
src/ex_pkg.sv
src/ex_operand_select.sv
src/ex_alu.sv
src/ex_branch_compare.sv
src/ex_resolve.sv
src/ex_stage.sv
bench/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module ex_stage_tb \
	-f ex_stage.f \
	-o ex_stage_sim \
	&& ./obj_dir/ex_stage_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "simulation run passed" \
	|| { echo "simulation run failed"; exit 1; }

// ==== src/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::ex_op_e            op,
	input  logic [ex_pkg::xlen-1:0]   a,
	input  logic [ex_pkg::xlen-1:0]   b,
	output logic [ex_pkg::xlen-1:0]   result
);
	import ex_pkg::*;

	logic [4:0]      shamt;
	logic [xlen-1:0] diff;
	logic            slt_bit;

	assign shamt   = b[4:0];  // upper bits ignored
	assign diff    = a - b;
	assign slt_bit = $signed(a) < $signed(b);

	// ####################################################################
	// opcode decode
	// ####################################################################
	always_comb begin
		case (op)
			op_nop: result = '0;
			op_add: result = a + b;
			op_sub: result = diff;
			op_and: result = a & b;
			op_or:  result = a | b;
			op_xor: result = a ^ b;
			op_sll: result = a << shamt;
			op_srl: result = a >> shamt;
			op_sra: result = $unsigned($signed(a) >>> shamt);
			op_slt: result = {{(xlen-1){1'b0}}, slt_bit};

			// branches still subtract
			op_beq,
			op_bne,
			op_blt,
			op_ble,
			op_bgt,
			op_bge: result = diff;

			op_jr:  result = a; // target passes through
			default: result = '0;
		endcase
	end

endmodule

// ==== src/ex_branch_compare.sv ====
`timescale 1ns/1ps

module ex_branch_compare (
	input  ex_pkg::ex_op_e            op,
	input  logic [ex_pkg::xlen-1:0]   a,
	input  logic [ex_pkg::xlen-1:0]   b,
	output ex_pkg::cmp_t              cmp
);
	import ex_pkg::*;

	logic [xlen-1:0] diff_bits;
	logic            eq;
	logic            ult;
	logic            sign_diff;
	logic            lt;
	logic            taken;

	// ####################################################################
	// equality and signed less-than
	// ####################################################################
	assign diff_bits = a ^ b;
	assign eq        = ~(|diff_bits); // nor of the xor bits

	assign ult       = a < b;              // unsigned
	assign sign_diff = a[xlen-1] ^ b[xlen-1];
	assign lt        = sign_diff ? a[xlen-1] : ult; // negative side is less

	// ####################################################################
	// branch condition
	// ####################################################################
	always_comb begin
		case (op)
			op_beq:  taken = eq;
			op_bne:  taken = ~eq;
			op_blt:  taken = lt;
			op_ble:  taken = lt | eq;
			op_bgt:  taken = ~lt & ~eq;
			op_bge:  taken = ~lt;
			default: taken = 1'b0; // not a branch
		endcase
	end

	always_comb begin
		cmp       = '0;
		cmp.eq    = eq;
		cmp.lt    = lt;
		cmp.taken = taken;
	end

endmodule

// ==== src/ex_operand_select.sv ====
`timescale 1ns/1ps

module ex_operand_select (
	input  ex_pkg::ex_in_t            in,
	output logic [ex_pkg::xlen-1:0]   op_a,
	output logic [ex_pkg::xlen-1:0]   op_b,
	output logic [ex_pkg::xlen-1:0]   store_data
);
	import ex_pkg::*;

	// operand a, pc path is for pc-relative adds
	always_comb begin
		case (in.sel_a)
			src_a_rs1: op_a = in.rs1;
			src_a_mem: op_a = in.mem_fwd;
			src_a_ex:  op_a = in.ex_fwd;
			src_a_pc:  op_a = in.pc;
			default:   op_a = in.rs1;
		endcase
	end

	// operand b
	always_comb begin
		case (in.sel_b)
			src_b_rs2:  op_b = in.rs2;
			src_b_mem:  op_b = in.mem_fwd;
			src_b_ex:   op_b = in.ex_fwd;
			src_b_zero: op_b = '0;
			src_b_imm:  op_b = in.imm;
			src_b_one:  op_b = {{(xlen-1){1'b0}}, 1'b1};
			default:    op_b = in.imm; // spare codes
		endcase
	end

	// store data forwards on its own, b may hold the offset
	always_comb begin
		case (in.sel_st)
			src_st_rs2: store_data = in.rs2;
			src_st_ex:  store_data = in.ex_fwd;
			src_st_mem: store_data = in.mem_fwd;
			default:    store_data = '0;
		endcase
	end

endmodule

// ==== src/ex_pkg.sv ====
package ex_pkg;

	// ####################################################################
	// widths
	// ####################################################################
	localparam int xlen      = 32;
	localparam int reg_idx_w = 5;

	// ####################################################################
	// opcodes and operand sources
	// ####################################################################
	typedef enum logic [4:0] {
		op_nop = 5'd0,
		op_add = 5'd1,
		op_sub = 5'd2,
		op_and = 5'd3,
		op_or  = 5'd4,
		op_xor = 5'd5,
		op_sll = 5'd6,
		op_srl = 5'd7,
		op_sra = 5'd8,
		op_slt = 5'd9,
		op_beq = 5'd10, // branches
		op_bne = 5'd11,
		op_blt = 5'd12,
		op_ble = 5'd13,
		op_bgt = 5'd14,
		op_bge = 5'd15,
		op_jr  = 5'd16  // register jump
	} ex_op_e;

	typedef enum logic [1:0] {
		src_a_rs1 = 2'd0,
		src_a_mem = 2'd1,
		src_a_ex  = 2'd2,
		src_a_pc  = 2'd3
	} src_a_e;

	// codes 5 and 6 are spare, decoded as immediate
	typedef enum logic [2:0] {
		src_b_rs2  = 3'd0,
		src_b_mem  = 3'd1,
		src_b_ex   = 3'd2,
		src_b_zero = 3'd3,
		src_b_imm  = 3'd4,
		src_b_one  = 3'd7
	} src_b_e;

	typedef enum logic [1:0] {
		src_st_rs2 = 2'd0,
		src_st_ex  = 2'd1,
		src_st_mem = 2'd2
	} src_st_e;

	// ####################################################################
	// stage structs
	// ####################################################################
	typedef struct packed {
		logic                 valid;
		ex_op_e               op;
		logic [xlen-1:0]      pc;
		logic [xlen-1:0]      rs1;
		logic [xlen-1:0]      rs2;
		logic [xlen-1:0]      imm;
		logic [xlen-1:0]      ex_fwd;   // result one stage ahead
		logic [xlen-1:0]      mem_fwd;  // result two stages ahead
		src_a_e               sel_a;
		src_b_e               sel_b;
		src_st_e              sel_st;
		logic [reg_idx_w-1:0] rd;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic                 predicted; // fetch guessed taken
		logic [xlen-1:0]      alt_pc;
	} ex_in_t;

	typedef struct packed {
		logic                 valid;
		logic [xlen-1:0]      alu_result;
		logic [xlen-1:0]      store_data;
		logic [reg_idx_w-1:0] rd;
		logic                 rd_nonzero;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic                 wrong_prediction;
		logic [xlen-1:0]      redirect_pc;
	} ex_out_t;

	typedef struct packed {
		logic eq;
		logic lt;    // signed
		logic taken;
	} cmp_t;

endpackage

// ==== src/ex_resolve.sv ====
`timescale 1ns/1ps

module ex_resolve (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ex_pkg::ex_in_t            in,
	input  logic [ex_pkg::xlen-1:0]   alu_result,
	input  logic [ex_pkg::xlen-1:0]   store_data,
	input  logic [ex_pkg::xlen-1:0]   jump_target,
	input  ex_pkg::cmp_t              cmp,
	output ex_pkg::ex_out_t           out
);
	import ex_pkg::*;

	logic            is_branch;
	logic            is_jump;
	logic            wrong;
	logic [xlen-1:0] redirect;
	ex_out_t         next;

	// ####################################################################
	// classify and check prediction
	// ####################################################################
	always_comb begin
		case (in.op)
			op_beq,
			op_bne,
			op_blt,
			op_ble,
			op_bgt,
			op_bge:  is_branch = 1'b1;
			default: is_branch = 1'b0;
		endcase
	end

	assign is_jump = (in.op == op_jr);

	// jr has no prediction, always redirects
	assign wrong = in.valid & ((is_branch & (cmp.taken != in.predicted)) | is_jump);

	always_comb begin
		if (!wrong)
			redirect = '0;
		else if (is_jump)
			redirect = jump_target;
		else
			redirect = in.alt_pc; // other way than predicted
	end

	// ####################################################################
	// EX/MEM register
	// ####################################################################
	always_comb begin
		next                  = '0;
		next.valid            = 1'b1;
		next.alu_result       = alu_result;
		next.store_data       = store_data;
		next.rd               = in.rd;
		next.rd_nonzero       = (in.rd != '0);
		next.reg_write        = in.reg_write;
		next.mem_read         = in.mem_read;
		next.mem_write        = in.mem_write;
		next.wrong_prediction = wrong;
		next.redirect_pc      = redirect;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out <= '0;
		else if (in.valid)
			out <= next;
		else
			out <= '0; // bubble
	end

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  ex_pkg::ex_in_t    in,
	output ex_pkg::ex_out_t   out
);
	import ex_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] store_data;
	logic [xlen-1:0] alu_result;
	cmp_t            cmp;

	// forwarding muxes
	ex_operand_select u_operand_select (
		.in         (in),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data)
	);

	// ####################################################################
	// alu and comparator share the operands
	// ####################################################################
	ex_alu u_alu (
		.op     (in.op),
		.a      (op_a),
		.b      (op_b),
		.result (alu_result)
	);

	ex_branch_compare u_branch_compare (
		.op  (in.op),
		.a   (op_a),
		.b   (op_b),
		.cmp (cmp)
	);

	ex_resolve u_resolve (
		.clk         (clk),
		.rst_n       (rst_n),
		.in          (in),
		.alu_result  (alu_result),
		.store_data  (store_data),
		.jump_target (op_a),     // jr target
		.cmp         (cmp),
		.out         (out)
	);

endmodule
